// File: Makefile
TOP = tb_ro

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ns -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns -f sim.f \
		--top-module $(TOP) -o sim_ro
	@out="$$(./obj_dir/sim_ro)"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

// File: exec_pipe.sv
/*
   Execute shadow pipeline. Results issued per slot move through s1, s2
   and s3 one stage per cycle and then sit in the commit stage, whose
   write ports feed the register file. Every stage is also exposed to the
   operand read stage for forwarding.
*/

`timescale 1ns/1ns
`default_nettype none

module exec_pipe
#(
   parameter int  CONFIG_DW            = ro_pkg::DEF_DW,
   parameter int  CONFIG_P_ISSUE_WIDTH = ro_pkg::DEF_P_ISSUE_WIDTH,
   localparam int IW                   = 1 << CONFIG_P_ISSUE_WIDTH,
   localparam int AW                   = ro_pkg::REG_AW
)
(
   input  wire                    clk,
   input  wire                    arst_n,
   input  wire [IW-1:0]           iss_we,
   input  wire [AW*IW-1:0]        iss_waddr,
   input  wire [CONFIG_DW*IW-1:0] iss_wdat,
   input  wire                    iss_load0,
   output wire [IW-1:0]           ex_s1_rf_we,
   output wire [AW*IW-1:0]        ex_s1_rf_waddr,
   output wire [CONFIG_DW*IW-1:0] ex_s1_rf_dout,
   output wire                    ex_s1_load0,
   output wire [IW-1:0]           ex_s2_rf_we,
   output wire [AW*IW-1:0]        ex_s2_rf_waddr,
   output wire [CONFIG_DW*IW-1:0] ex_s2_rf_dout,
   output wire                    ex_s2_load0,
   output wire [IW-1:0]           ex_s3_rf_we,
   output wire [AW*IW-1:0]        ex_s3_rf_waddr,
   output wire [CONFIG_DW*IW-1:0] ex_s3_rf_dout,
   output wire                    ex_s3_load0,
   output wire [IW-1:0]           cmt_rf_we,
   output wire [AW*IW-1:0]        cmt_rf_waddr,
   output wire [CONFIG_DW*IW-1:0] cmt_rf_wdat
);

   localparam int NST = ro_pkg::NUM_EX_STAGES;  // index NST is the commit stage

   logic [IW-1:0]           we_q    [NST+1];
   logic [AW*IW-1:0]        waddr_q [NST+1];
   logic [CONFIG_DW*IW-1:0] dat_q   [NST+1];
   logic [NST-1:0]          load0_q;            // commit never needs the flag

   // ********************************************************************
   // control, cleared on reset
   // ********************************************************************
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int s = 0; s <= NST; s++)
            we_q[s] <= '0;
         load0_q <= '0;
      end
      else
      begin
         we_q[0] <= iss_we;
         for (int s = 1; s <= NST; s++)
            we_q[s] <= we_q[s-1];
         load0_q <= {load0_q[NST-2:0], iss_load0 & iss_we[0]};  // a load needs a write
      end
   end

   // payload just follows its enable down the pipe
   always_ff @(posedge clk)
   begin
      waddr_q[0] <= iss_waddr;
      dat_q[0]   <= iss_wdat;
      for (int s = 1; s <= NST; s++)
      begin
         waddr_q[s] <= waddr_q[s-1];
         dat_q[s]   <= dat_q[s-1];
      end
   end

   assign ex_s1_rf_we    = we_q[0];
   assign ex_s1_rf_waddr = waddr_q[0];
   assign ex_s1_rf_dout  = dat_q[0];
   assign ex_s1_load0    = load0_q[0];
   assign ex_s2_rf_we    = we_q[1];
   assign ex_s2_rf_waddr = waddr_q[1];
   assign ex_s2_rf_dout  = dat_q[1];
   assign ex_s2_load0    = load0_q[1];
   assign ex_s3_rf_we    = we_q[2];
   assign ex_s3_rf_waddr = waddr_q[2];
   assign ex_s3_rf_dout  = dat_q[2];
   assign ex_s3_load0    = load0_q[2];
   assign cmt_rf_we      = we_q[NST];
   assign cmt_rf_waddr   = waddr_q[NST];
   assign cmt_rf_wdat    = dat_q[NST];

   a_iss_we_known: assert property (@(posedge clk) disable iff (!arst_n)
      !$isunknown(iss_we))
      else $error("issue write enable is unknown");

endmodule

`default_nettype wire

// File: id_ro.sv
/*
   Operand read stage. Each read channel is compared against the writes
   in s1, s2, s3 and commit; the matches and stage data are captured with
   the register file read, and a cycle later the youngest match overrides
   rf_din. raw_dep_load0 flags reads that depend on a load still in flight.
*/

`timescale 1ns/1ns
`default_nettype none

module id_ro
#(
   parameter int  CONFIG_DW            = ro_pkg::DEF_DW,
   parameter int  CONFIG_P_ISSUE_WIDTH = ro_pkg::DEF_P_ISSUE_WIDTH,
   localparam int IW                   = 1 << CONFIG_P_ISSUE_WIDTH,
   localparam int CHS                  = 2 * IW,
   localparam int AW                   = ro_pkg::REG_AW
)
(
   input  wire                     clk,
   input  wire                     arst_n,
   input  wire [IW-1:0]            ex_s1_rf_we,
   input  wire [AW*IW-1:0]         ex_s1_rf_waddr,
   input  wire [CONFIG_DW*IW-1:0]  ex_s1_rf_dout,
   input  wire                     ex_s1_load0,
   input  wire [IW-1:0]            ex_s2_rf_we,
   input  wire [AW*IW-1:0]         ex_s2_rf_waddr,
   input  wire [CONFIG_DW*IW-1:0]  ex_s2_rf_dout,
   input  wire                     ex_s2_load0,
   input  wire [IW-1:0]            ex_s3_rf_we,
   input  wire [AW*IW-1:0]         ex_s3_rf_waddr,
   input  wire [CONFIG_DW*IW-1:0]  ex_s3_rf_dout,
   input  wire                     ex_s3_load0,
   input  wire [IW-1:0]            cmt_rf_we,
   input  wire [AW*IW-1:0]         cmt_rf_waddr,
   input  wire [CONFIG_DW*IW-1:0]  cmt_rf_wdat,
   input  wire [CHS-1:0]           re,
   input  wire [AW*CHS-1:0]        raddr,
   input  wire [CONFIG_DW*CHS-1:0] rf_din,
   output wire [CONFIG_DW*CHS-1:0] byp_dout,
   output wire [CHS-1:0]           raw_dep_load0
);

   localparam int NLD  = ro_pkg::NUM_EX_STAGES;  // stages that may hold a load
   localparam int NSRC = NLD + 1;                // forwarding sources, youngest first

   logic [IW-1:0]           src_we    [NSRC];
   logic [AW*IW-1:0]        src_waddr [NSRC];
   logic [CONFIG_DW*IW-1:0] src_dat   [NSRC];
   logic [CONFIG_DW*IW-1:0] dat_q     [NSRC];
   logic [CONFIG_DW*IW-1:0] dat_rev   [NSRC];
   logic [NLD-1:0]          src_load0;
   wire                     p_ce;

   assign src_we    = '{ex_s1_rf_we, ex_s2_rf_we, ex_s3_rf_we, cmt_rf_we};
   assign src_waddr = '{ex_s1_rf_waddr, ex_s2_rf_waddr, ex_s3_rf_waddr, cmt_rf_waddr};
   assign src_dat   = '{ex_s1_rf_dout, ex_s2_rf_dout, ex_s3_rf_dout, cmt_rf_wdat};
   assign src_load0 = {ex_s3_load0, ex_s2_load0, ex_s1_load0};
   assign p_ce      = |re;  // capture only alongside a register file read

   // ********************************************************************
   // stage data captured with the read, slot order reversed for the muxes
   // ********************************************************************
   always_ff @(posedge clk)
   begin
      if (p_ce)
         dat_q <= src_dat;
   end

   always_comb
   begin
      for (int s = 0; s < NSRC; s++)
         for (int k = 0; k < IW; k++)
            dat_rev[s][(IW-1-k)*CONFIG_DW +: CONFIG_DW] = dat_q[s][k*CONFIG_DW +: CONFIG_DW];
   end

   // ********************************************************************
   // per channel match, capture and select
   // ********************************************************************
   for (genvar i = 0; i < CHS; i++)
   begin : g_ch
      logic [IW-1:0]        hit       [NSRC];
      logic [IW-1:0]        hit_rev   [NSRC];
      logic [IW-1:0]        hit_rev_q [NSRC];
      wire  [CONFIG_DW-1:0] sel_dat   [NSRC];
      wire  [NSRC-1:0]      use_src;
      logic [CONFIG_DW-1:0] dout;
      logic                 dep;

      always_comb
      begin
         dep = 1'b0;
         for (int s = 0; s < NSRC; s++)
         begin
            for (int k = 0; k < IW; k++)
            begin
               hit[s][k] = re[i] & src_we[s][k] &
                           (src_waddr[s][k*AW +: AW] == raddr[i*AW +: AW]);
               hit_rev[s][IW-1-k] = hit[s][k];
            end
         end
         for (int s = 0; s < NLD; s++)
            dep = dep | (hit[s][0] & src_load0[s]);  // only slot 0 carries loads
      end

      assign raw_dep_load0[i] = dep;

      always_ff @(posedge clk or negedge arst_n)
      begin
         if (!arst_n)
         begin
            for (int s = 0; s < NSRC; s++)
               hit_rev_q[s] <= '0;
         end
         else if (p_ce)
            hit_rev_q <= hit_rev;
      end

      for (genvar s = 0; s < NSRC; s++)
      begin : g_src
         prio_mux #(.SELW(IW), .DW(CONFIG_DW)) u_pmux (
            .sel   (hit_rev_q[s]),
            .din   (dat_rev[s]),
            .dout  (sel_dat[s]),
            .valid (use_src[s])
         );
      end

      // oldest source first so the youngest match overwrites it
      always_comb
      begin
         dout = rf_din[i*CONFIG_DW +: CONFIG_DW];
         for (int s = NSRC - 1; s >= 0; s--)
         begin
            if (use_src[s])
               dout = sel_dat[s];
         end
      end

      assign byp_dout[i*CONFIG_DW +: CONFIG_DW] = dout;
   end

   a_load0_has_we: assert property (@(posedge clk) disable iff (!arst_n)
      !(ex_s1_load0 && !ex_s1_rf_we[0]) && !(ex_s2_load0 && !ex_s2_rf_we[0]) &&
      !(ex_s3_load0 && !ex_s3_rf_we[0]))
      else $error("load flag set on a stage with no slot 0 write");

endmodule

`default_nettype wire

// File: prio_mux.sv
/*
   Priority selector from a select vector to one data slice.
   The lowest set select bit wins; valid flags that any bit was set.
   Callers wanting the highest slot to win feed bit-reversed vectors.
*/

`timescale 1ns/1ns
`default_nettype none

module prio_mux
#(
   parameter int SELW = 2,
   parameter int DW   = 32
)
(
   input  wire [SELW-1:0]    sel,
   input  wire [SELW*DW-1:0] din,
   output logic [DW-1:0]     dout,
   output wire               valid
);

   // scan from the top so the lowest set bit is the last to land
   always_comb
   begin
      dout = '0;
      for (int k = SELW - 1; k >= 0; k--)
      begin
         if (sel[k])
            dout = din[k*DW +: DW];
      end
   end

   assign valid = |sel;  // at least one source matched

endmodule

`default_nettype wire

// File: reg_file.sv
/*
   Register file with one write port per issue slot and two synchronous
   read ports per slot. Data for a read enabled in one cycle appears on
   rf_din in the next; a channel with re low keeps its last output.
*/

`timescale 1ns/1ns
`default_nettype none

module reg_file
#(
   parameter int  CONFIG_DW            = ro_pkg::DEF_DW,
   parameter int  CONFIG_P_ISSUE_WIDTH = ro_pkg::DEF_P_ISSUE_WIDTH,
   localparam int IW                   = 1 << CONFIG_P_ISSUE_WIDTH,
   localparam int CHS                  = 2 * IW,
   localparam int AW                   = ro_pkg::REG_AW
)
(
   input  wire                      clk,
   input  wire                      arst_n,
   input  wire [IW-1:0]             we,
   input  wire [AW*IW-1:0]          waddr,
   input  wire [CONFIG_DW*IW-1:0]   wdat,
   input  wire [CHS-1:0]            re,
   input  wire [AW*CHS-1:0]         raddr,
   output logic [CONFIG_DW*CHS-1:0] rf_din
);

   logic [CONFIG_DW-1:0] mem [ro_pkg::NUM_REGS];

   // later slots overwrite earlier ones on a shared address
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int r = 0; r < ro_pkg::NUM_REGS; r++)
            mem[r] <= '0;
      end
      else
      begin
         for (int k = 0; k < IW; k++)
         begin
            if (we[k])
               mem[waddr[k*AW +: AW]] <= wdat[k*CONFIG_DW +: CONFIG_DW];
         end
      end
   end

   // a write in the same cycle is not visible here, the bypass covers it
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         rf_din <= '0;
      else
      begin
         for (int i = 0; i < CHS; i++)
         begin
            if (re[i])
               rf_din[i*CONFIG_DW +: CONFIG_DW] <= mem[raddr[i*AW +: AW]];
         end
      end
   end

   for (genvar k = 0; k < IW; k++)
   begin : g_chk
      a_waddr_known: assert property (@(posedge clk) disable iff (!arst_n)
         we[k] |-> !$isunknown(waddr[k*AW +: AW]))
         else $error("write address of slot %0d is unknown", k);
   end

endmodule

`default_nettype wire

// File: ro_pkg.sv
/*
   Shared widths and counts for the operand read stage and its feeders.
   Modules and the testbench reference these as ro_pkg::name; the DEF_
   values are the defaults that the top level passes down as parameters.
*/

`default_nettype none

package ro_pkg;

   // ********************************************************************
   // register file geometry
   // ********************************************************************
   localparam int REG_AW            = 5;   // register address width
   localparam int NUM_REGS          = 32;  // architectural registers

   // ********************************************************************
   // datapath defaults
   // ********************************************************************
   localparam int DEF_DW            = 32;  // data width, 64 also works
   localparam int DEF_P_ISSUE_WIDTH = 1;   // log2 of issue slots, two slots

   // execute shadow stages s1, s2, s3 ahead of commit
   localparam int NUM_EX_STAGES     = 3;

endpackage

`default_nettype wire

// File: ro_top.sv
/*
   Top level of the operand read block. The execute shadow pipeline
   commits into the register file, and the read stage combines register
   file reads with forwarding from every in-flight stage. Read data is
   valid exactly one cycle after re.
*/

`timescale 1ns/1ns
`default_nettype none

module ro_top
#(
   parameter int  CONFIG_DW            = ro_pkg::DEF_DW,
   parameter int  CONFIG_P_ISSUE_WIDTH = ro_pkg::DEF_P_ISSUE_WIDTH,
   localparam int IW                   = 1 << CONFIG_P_ISSUE_WIDTH,
   localparam int CHS                  = 2 * IW,
   localparam int AW                   = ro_pkg::REG_AW
)
(
   input  wire                     clk,
   input  wire                     arst_n,
   input  wire [IW-1:0]            iss_we,
   input  wire [AW*IW-1:0]         iss_waddr,
   input  wire [CONFIG_DW*IW-1:0]  iss_wdat,
   input  wire                     iss_load0,
   input  wire [CHS-1:0]           re,
   input  wire [AW*CHS-1:0]        raddr,
   output wire [CONFIG_DW*CHS-1:0] byp_dout,
   output wire [CHS-1:0]           raw_dep_load0
);

   wire [IW-1:0]            s1_we, s2_we, s3_we, cmt_we;
   wire [AW*IW-1:0]         s1_waddr, s2_waddr, s3_waddr, cmt_waddr;
   wire [CONFIG_DW*IW-1:0]  s1_dat, s2_dat, s3_dat, cmt_dat;
   wire                     s1_load0, s2_load0, s3_load0;
   wire [CONFIG_DW*CHS-1:0] rf_din;

   exec_pipe #(.CONFIG_DW(CONFIG_DW), .CONFIG_P_ISSUE_WIDTH(CONFIG_P_ISSUE_WIDTH)) u_exec_pipe (
      .clk(clk), .arst_n(arst_n),
      .iss_we(iss_we), .iss_waddr(iss_waddr), .iss_wdat(iss_wdat), .iss_load0(iss_load0),
      .ex_s1_rf_we(s1_we), .ex_s1_rf_waddr(s1_waddr), .ex_s1_rf_dout(s1_dat),
      .ex_s1_load0(s1_load0),
      .ex_s2_rf_we(s2_we), .ex_s2_rf_waddr(s2_waddr), .ex_s2_rf_dout(s2_dat),
      .ex_s2_load0(s2_load0),
      .ex_s3_rf_we(s3_we), .ex_s3_rf_waddr(s3_waddr), .ex_s3_rf_dout(s3_dat),
      .ex_s3_load0(s3_load0),
      .cmt_rf_we(cmt_we), .cmt_rf_waddr(cmt_waddr), .cmt_rf_wdat(cmt_dat)
   );

   reg_file #(.CONFIG_DW(CONFIG_DW), .CONFIG_P_ISSUE_WIDTH(CONFIG_P_ISSUE_WIDTH)) u_reg_file (
      .clk(clk), .arst_n(arst_n),
      .we(cmt_we), .waddr(cmt_waddr), .wdat(cmt_dat),
      .re(re), .raddr(raddr), .rf_din(rf_din)
   );

   id_ro #(.CONFIG_DW(CONFIG_DW), .CONFIG_P_ISSUE_WIDTH(CONFIG_P_ISSUE_WIDTH)) u_id_ro (
      .clk(clk), .arst_n(arst_n),
      .ex_s1_rf_we(s1_we), .ex_s1_rf_waddr(s1_waddr), .ex_s1_rf_dout(s1_dat),
      .ex_s1_load0(s1_load0),
      .ex_s2_rf_we(s2_we), .ex_s2_rf_waddr(s2_waddr), .ex_s2_rf_dout(s2_dat),
      .ex_s2_load0(s2_load0),
      .ex_s3_rf_we(s3_we), .ex_s3_rf_waddr(s3_waddr), .ex_s3_rf_dout(s3_dat),
      .ex_s3_load0(s3_load0),
      .cmt_rf_we(cmt_we), .cmt_rf_waddr(cmt_waddr), .cmt_rf_wdat(cmt_dat),
      .re(re), .raddr(raddr), .rf_din(rf_din),
      .byp_dout(byp_dout), .raw_dep_load0(raw_dep_load0)
   );

endmodule

`default_nettype wire

// File: sim.f
ro_pkg.sv
prio_mux.sv
exec_pipe.sv
reg_file.sv
id_ro.sv
ro_top.sv
tb_ro_checker.sv
tb_ro.sv

// File: tb_ro.sv
/*
   Testbench for the operand read block. Drives random issue and read
   streams on the falling clock edge, keeps a reference model of the
   register file and the four in-flight stages, and hands the expected
   outputs to the checker, which compares them at each rising edge.
   Prints one line per test, a closing count line and the verdict.
*/

`timescale 1ns/1ns
`default_nettype none

module tb_ro;

   localparam int DW     = ro_pkg::DEF_DW;
   localparam int IW     = 1 << ro_pkg::DEF_P_ISSUE_WIDTH;
   localparam int CHS    = 2 * IW;
   localparam int AW     = ro_pkg::REG_AW;
   localparam int NQ     = ro_pkg::NUM_EX_STAGES + 1;  // s1, s2, s3, then commit
   localparam int CLK_NS = 40;

   logic                clk = 1'b0;
   logic                arst_n;
   logic [IW-1:0]       iss_we;
   logic [AW*IW-1:0]    iss_waddr;
   logic [DW*IW-1:0]    iss_wdat;
   logic                iss_load0;
   logic [CHS-1:0]      re;
   logic [AW*CHS-1:0]   raddr;
   wire  [DW*CHS-1:0]   byp_dout;
   wire  [CHS-1:0]      raw_dep_load0;

   // reference model state
   logic [DW-1:0]       rf_model [ro_pkg::NUM_REGS];
   logic [IW-1:0]       q_we     [NQ];
   logic [AW-1:0]       q_addr   [NQ][IW];
   logic [DW-1:0]       q_dat    [NQ][IW];
   logic                q_ld     [NQ];
   logic [DW-1:0]       last_rf  [CHS];       // what each rf_din channel holds
   logic [DW*CHS-1:0]   exp_byp;
   logic [DW*CHS-1:0]   nxt_byp;
   logic [CHS-1:0]      exp_dep;
   logic                check_en;
   wire  [31:0]         err_cnt;
   wire  [31:0]         chk_cnt;

   integer              seed;
   int                  err_mark;
   int                  chk_mark;
   int                  tests_ok;
   int                  tests_bad;

   always #(CLK_NS / 2) clk = ~clk;

   ro_top DUT (
      .clk(clk), .arst_n(arst_n),
      .iss_we(iss_we), .iss_waddr(iss_waddr), .iss_wdat(iss_wdat), .iss_load0(iss_load0),
      .re(re), .raddr(raddr),
      .byp_dout(byp_dout), .raw_dep_load0(raw_dep_load0)
   );

   tb_ro_checker #(.DW(DW), .CHS(CHS)) u_checker (
      .clk(clk), .en(check_en),
      .byp_dout(byp_dout), .raw_dep_load0(raw_dep_load0),
      .exp_byp(exp_byp), .exp_dep(exp_dep),
      .err_cnt(err_cnt), .chk_cnt(chk_cnt)
   );

   // *********************************************************************
   // clock waits and stimulus helpers
   // *********************************************************************
   task automatic wait_falls(input int n);
      for (int c = 0; c < n; c++)
      begin
         fork
            begin
               #(2 * CLK_NS);
               $display("timeout: no falling clock edge within %0d ns", 2 * CLK_NS);
               $display("TB FAILED");
               $finish;
            end
         join_none
         @(negedge clk);
         disable fork;
      end
   endtask

   function automatic bit chance(input int pct);
      logic [31:0] r;
      r = $random(seed);
      return (r % 32'd100) < pct;
   endfunction

   function automatic logic [AW-1:0] narrow_addr();
      logic [31:0] r;
      r = $random(seed);
      return AW'(r[2:0]);  // eight registers keep matches frequent
   endfunction

   task automatic clear_inputs();
      iss_we    = '0;
      iss_waddr = '0;
      iss_wdat  = '0;
      iss_load0 = 1'b0;
      re        = '0;
      raddr     = '0;
   endtask

   task automatic rand_inputs(input int ld_pct, input int rd_pct);
      logic [31:0] r;
      for (int k = 0; k < IW; k++)
      begin
         r = $random(seed);
         iss_we[k] = r[0];
         iss_waddr[k*AW +: AW] = narrow_addr();
         iss_wdat[k*DW +: DW] = r;
      end
      iss_load0 = chance(ld_pct);
      for (int i = 0; i < CHS; i++)
      begin
         re[i] = chance(rd_pct);
         raddr[i*AW +: AW] = narrow_addr();
      end
   endtask

   // *********************************************************************
   // model stepped once per cycle right after the inputs change
   // *********************************************************************
   task automatic model_update();
      logic [DW-1:0] v;
      logic [AW-1:0] a;
      logic          hit;
      exp_byp = nxt_byp;
      for (int i = 0; i < CHS; i++)
      begin
         a = raddr[i*AW +: AW];
         exp_dep[i] = 1'b0;
         for (int s = 0; s < NQ - 1; s++)  // commit stage never counts
            if (re[i] && q_we[s][0] && q_ld[s] && q_addr[s][0] == a)
               exp_dep[i] = 1'b1;
         if (|re)
         begin
            if (re[i])
            begin
               last_rf[i] = rf_model[a];  // old value since the commit lands at the edge
               v = last_rf[i];
               hit = 1'b0;
               for (int s = 0; s < NQ; s++)
                  for (int k = IW - 1; k >= 0; k--)
                     if (!hit && q_we[s][k] && q_addr[s][k] == a)
                     begin
                        v = q_dat[s][k];
                        hit = 1'b1;
                     end
            end
            else
               v = last_rf[i];
            nxt_byp[i*DW +: DW] = v;
         end
      end
      for (int k = 0; k < IW; k++)
         if (q_we[NQ-1][k])
            rf_model[q_addr[NQ-1][k]] = q_dat[NQ-1][k];
      for (int s = NQ - 1; s > 0; s--)
      begin
         q_we[s] = q_we[s-1];
         q_addr[s] = q_addr[s-1];
         q_dat[s] = q_dat[s-1];
         q_ld[s] = q_ld[s-1];
      end
      q_we[0] = iss_we;
      q_ld[0] = iss_load0 & iss_we[0];
      for (int k = 0; k < IW; k++)
      begin
         q_addr[0][k] = iss_waddr[k*AW +: AW];
         q_dat[0][k] = iss_wdat[k*DW +: DW];
      end
   endtask

   task automatic idle_cycle();
      wait_falls(1);
      clear_inputs();
      model_update();
   endtask

   task automatic random_cycles(input int n, input int ld_pct, input int rd_pct,
                                input int quiet_pct);
      for (int c = 0; c < n; c++)
      begin
         wait_falls(1);
         rand_inputs(ld_pct, rd_pct);
         if (chance(quiet_pct))
            re = '0;
         model_update();
      end
   endtask

   // issue one value, let it age, then read it on every channel
   task automatic issue_then_read(input int slot, input logic [AW-1:0] a, input int gap);
      logic [31:0] r;
      r = $random(seed);
      wait_falls(1);
      clear_inputs();
      iss_we[slot] = 1'b1;
      iss_waddr[slot*AW +: AW] = a;
      iss_wdat[slot*DW +: DW] = r;
      model_update();
      for (int c = 0; c < gap; c++)
         idle_cycle();
      wait_falls(1);
      clear_inputs();
      re = '1;
      raddr = {CHS{a}};
      model_update();
   endtask

   task automatic end_test(input string name);
      int errs;
      int chks;
      idle_cycle();
      idle_cycle();  // last read result has now been compared
      errs = int'(err_cnt) - err_mark;
      chks = int'(chk_cnt) - chk_mark;
      if (errs == 0 && chks > 0)
      begin
         tests_ok++;
         $display("test %s: ok, %0d checks", name, chks);
      end
      else
      begin
         tests_bad++;
         if (chks == 0)
            $display("test %s: no comparisons were made", name);
         else
            $display("test %s: %0d errors in %0d checks", name, errs, chks);
      end
      err_mark = int'(err_cnt);
      chk_mark = int'(chk_cnt);
   endtask

   // *********************************************************************
   // test sequence
   // *********************************************************************
   initial
   begin
      seed = 32'h39071487;
      clear_inputs();
      arst_n = 1'b0;
      check_en = 1'b0;
      exp_byp = '0;
      nxt_byp = '0;
      exp_dep = '0;
      err_mark = 0;
      chk_mark = 0;
      tests_ok = 0;
      tests_bad = 0;
      for (int r = 0; r < ro_pkg::NUM_REGS; r++)
         rf_model[r] = '0;
      for (int s = 0; s < NQ; s++)
      begin
         q_we[s] = '0;
         q_ld[s] = 1'b0;
      end
      for (int i = 0; i < CHS; i++)
         last_rf[i] = '0;

      wait_falls(4);  // four cycles of reset
      arst_n = 1'b1;
      check_en = 1'b1;

      for (int c = 0; c < 8; c++)
      begin
         wait_falls(1);
         clear_inputs();
         for (int i = 0; i < CHS; i++)
         begin
            re[i] = chance(70);
            raddr[i*AW +: AW] = AW'($random(seed));  // whole register range
         end
         model_update();
      end
      end_test("1 reset state");

      issue_then_read(1, AW'(3), 5);
      issue_then_read(0, AW'(6), 7);
      end_test("2 register file path");

      random_cycles(300, 0, 60, 0);
      end_test("3 stage forwarding priority");

      for (int j = 0; j < 4; j++)
         issue_then_read(j % IW, AW'(4 + j), 3);  // read while in commit
      end_test("4 same-cycle commit");

      random_cycles(200, 60, 70, 0);
      end_test("5 load dependency");

      random_cycles(150, 20, 60, 50);
      end_test("6 hold with no reads");

      $display("tests: %0d ok, %0d failed; checks: %0d, errors: %0d",
               tests_ok, tests_bad, chk_cnt, err_cnt);
      if (tests_bad == 0 && err_cnt == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: tb_ro_checker.sv
/*
   Output checker for the operand read testbench. At each rising edge
   it compares byp_dout and raw_dep_load0 of every channel against the
   expected values from the model, prints an error line on a mismatch
   and keeps the comparison and error counts for the closing report.
*/

`timescale 1ns/1ns
`default_nettype none

module tb_ro_checker
#(
   parameter int DW  = 32,
   parameter int CHS = 4
)
(
   input  wire              clk,
   input  wire              en,
   input  wire [DW*CHS-1:0] byp_dout,
   input  wire [CHS-1:0]    raw_dep_load0,
   input  wire [DW*CHS-1:0] exp_byp,
   input  wire [CHS-1:0]    exp_dep,
   output wire [31:0]       err_cnt,
   output wire [31:0]       chk_cnt
);

   int errs = 0;
   int chks = 0;

   assign err_cnt = errs;
   assign chk_cnt = chks;

   // *********************************************************************
   // per channel comparison, outputs are stable across the rising edge
   // *********************************************************************
   always @(posedge clk)
   begin
      if (en)
      begin
         for (int i = 0; i < CHS; i++)
         begin
            chks = chks + 2;
            if (byp_dout[i*DW +: DW] !== exp_byp[i*DW +: DW])
            begin
               errs = errs + 1;
               $display("[ERROR] byp_dout[%0d] expected 0x%h actual 0x%h at %0t ns",
                        i, exp_byp[i*DW +: DW], byp_dout[i*DW +: DW], $time);
            end
            if (raw_dep_load0[i] !== exp_dep[i])
            begin
               errs = errs + 1;
               $display("[ERROR] raw_dep_load0[%0d] expected 0x%h actual 0x%h at %0t ns",
                        i, exp_dep[i], raw_dep_load0[i], $time);
            end
         end
      end
   end

endmodule

`default_nettype wire
